//--- include/nor_defs_defs.svh
// nor flash sequencer widths and table sizes
// shared by the command set and bus side packages

`ifndef NOR_DEFS_DEFS_SVH
`define NOR_DEFS_DEFS_SVH

// opcode field in the upper request address bits
`define NOR_CMD_BITS 6

// flash word address below the opcode
`define NOR_ADDR_BITS 26

// flash data bus
`define NOR_DATA_BITS 16

// longest unlock sequence, erase commands
`define NOR_MAX_CYCLES 6

// enough to count up to NOR_MAX_CYCLES
`define NOR_IDX_BITS 3

// fixed unlock addresses only use the low bits
`define NOR_CONST_ADDR_BITS 12

`endif

//--- rtl/nor_cmd_pkg.sv
// nor flash command set types
// opcodes and the fields of one command table entry

`include "nor_defs_defs.svh"

package nor_cmd_pkg;

    // opcode carried above the flash address in a request
    typedef enum logic [`NOR_CMD_BITS-1:0] {
        CMD_READ         = 6'd0,
        CMD_CFI_ENTER    = 6'd1,
        CMD_PROGRAM      = 6'd2,
        CMD_ERASE_SECTOR = 6'd3,
        CMD_ERASE_CHIP   = 6'd4,
        CMD_RESET        = 6'd5,
        CMD_WRITE_BUF    = 6'd6,
        CMD_PROG_BUF     = 6'd7,
        CMD_WRITE        = 6'd8
    } nor_cmd_e;

    // index of a bus cycle within one command, also used for counts
    typedef logic [`NOR_IDX_BITS-1:0] cycle_idx_t;

    // unlock address as stored in the table
    typedef logic [`NOR_CONST_ADDR_BITS-1:0] const_addr_t;

endpackage

//--- rtl/nor_bus_pkg.sv
// nor flash bus side types
// address and data words plus the cycle engine states

`include "nor_defs_defs.svh"

package nor_bus_pkg;

    // flash word address on the master port
    typedef logic [`NOR_ADDR_BITS-1:0] nor_addr_t;

    // data word on both ports
    typedef logic [`NOR_DATA_BITS-1:0] nor_data_t;

    // slave request address, opcode on top of flash address
    typedef logic [`NOR_CMD_BITS+`NOR_ADDR_BITS-1:0] req_addr_t;

    // master side sequencing
    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,
        SEQ_ISSUE = 2'd1,
        SEQ_WAIT  = 2'd2
    } seq_state_e;

endpackage

//--- rtl/nor_cmd_table.sv
// nor command table
// maps opcode and cycle index to cycle count and unlock address/data

`timescale 1ns/1ps

`include "nor_defs_defs.svh"

module nor_cmd_table
    import nor_cmd_pkg::*;
    import nor_bus_pkg::*;
(
    input  nor_cmd_e    cmd_i,
    input  cycle_idx_t  cycle_i,
    output cycle_idx_t  cycle_cnt_o,
    output const_addr_t const_addr_o,
    output nor_data_t   const_data_o,
    // 1 = take the caller's address for this cycle
    output logic        addr_sel_o,
    // 1 = take the caller's data for this cycle
    output logic        data_sel_o
);

    always_comb begin
        // unknown opcodes behave like a reset command
        cycle_cnt_o  = cycle_idx_t'(1);
        const_addr_o = '0;
        const_data_o = 16'h00F0;
        addr_sel_o   = 1'b0;
        data_sel_o   = 1'b0;

        case (cmd_i)
            // single cycle straight through
            CMD_READ, CMD_WRITE: begin
                const_data_o = '0;
                addr_sel_o   = 1'b1;
                data_sel_o   = 1'b1;
            end

            // cfi query entry
            CMD_CFI_ENTER: begin
                const_addr_o = 12'h055;
                const_data_o = 16'h0098;
            end

            // two unlock cycles, then program setup or buffer words
            CMD_PROGRAM, CMD_WRITE_BUF: begin
                cycle_cnt_o = cycle_idx_t'(4);
                case (cycle_i)
                    0: begin
                        const_addr_o = 12'h555;
                        const_data_o = 16'h00AA;
                    end
                    1: begin
                        const_addr_o = 12'h2AA;
                        const_data_o = 16'h0055;
                    end
                    2: begin
                        if (cmd_i == CMD_PROGRAM) begin
                            const_addr_o = 12'h555;
                            const_data_o = 16'h00A0;
                        end else begin
                            addr_sel_o = 1'b1;
                            data_sel_o = 1'b1;
                        end
                    end
                    default: begin
                        // last word comes from the caller
                        addr_sel_o = 1'b1;
                        data_sel_o = 1'b1;
                    end
                endcase
            end

            // erase setup is unlock, 80, unlock again, then the target
            CMD_ERASE_SECTOR, CMD_ERASE_CHIP: begin
                cycle_cnt_o = cycle_idx_t'(6);
                case (cycle_i)
                    0, 3: begin
                        const_addr_o = 12'h555;
                        const_data_o = 16'h00AA;
                    end
                    1, 4: begin
                        const_addr_o = 12'h2AA;
                        const_data_o = 16'h0055;
                    end
                    2: begin
                        const_addr_o = 12'h555;
                        const_data_o = 16'h0080;
                    end
                    default: begin
                        if (cmd_i == CMD_ERASE_SECTOR) begin
                            // sector address from the caller
                            addr_sel_o   = 1'b1;
                            const_data_o = 16'h0030;
                        end else begin
                            const_addr_o = 12'h555;
                            const_data_o = 16'h0010;
                        end
                    end
                endcase
            end

            // back to read array mode
            CMD_RESET: begin
                const_data_o = 16'h00F0;
            end

            // confirm buffer program at the sector address
            CMD_PROG_BUF: begin
                addr_sel_o   = 1'b1;
                const_data_o = 16'h0029;
            end

            default: begin
            end
        endcase
    end

endmodule

//--- rtl/nor_req_latch.sv
// slave side request latch
// captures one request, holds stall until ack, forms abort

`timescale 1ns/1ps

`include "nor_defs_defs.svh"

module nor_req_latch
    import nor_cmd_pkg::*;
    import nor_bus_pkg::*;
(
    input  logic      wb_clk_i,
    input  logic      mod_reset,
    input  req_addr_t wbs_adr_i,
    input  nor_data_t wbs_dat_i,
    input  logic      wbs_stb_i,
    input  logic      wbs_cyc_i,
    input  logic      wbm_err_i,
    input  logic      done_i,
    input  nor_data_t rd_data_i,
    output logic      wbs_ack_o,
    output logic      wbs_stall_o,
    output logic      wbs_err_o,
    output nor_data_t wbs_dat_o,
    output logic      start_o,
    output logic      abort_o,
    output nor_cmd_e  cmd_o,
    output nor_addr_t addr_o,
    output nor_data_t data_o
);

    logic busy;
    logic accept;

    // downstream error goes straight back to the caller
    assign wbs_err_o = wbm_err_i;

    // reset, caller giving up, or flash error
    assign abort_o = mod_reset || !wbs_cyc_i || wbm_err_i;

    // one request in flight, stall until it is acked
    assign wbs_stall_o = busy;
    assign accept      = wbs_stb_i && !busy;

    always_ff @(posedge wb_clk_i) begin
        if (abort_o) begin
            busy      <= 1'b0;
            start_o   <= 1'b0;
            wbs_ack_o <= 1'b0;
        end else begin
            // start pulse lines up with the new payload
            start_o   <= accept;
            // ack follows the engine's done by one edge
            wbs_ack_o <= done_i;
            if (accept) begin
                busy <= 1'b1;
            end else if (done_i) begin
                busy <= 1'b0;
            end
        end
    end

    // payload, split into opcode and flash address
    always_ff @(posedge wb_clk_i) begin
        if (accept) begin
            cmd_o  <= nor_cmd_e'(wbs_adr_i[`NOR_ADDR_BITS +: `NOR_CMD_BITS]);
            addr_o <= wbs_adr_i[`NOR_ADDR_BITS-1:0];
            data_o <= wbs_dat_i;
        end
    end

    // read data is only meaningful for read commands
    always_ff @(posedge wb_clk_i) begin
        if (done_i && cmd_o == CMD_READ) begin
            wbs_dat_o <= rd_data_i;
        end
    end

    // the engine must never complete into a flash error
    a_ack_err_excl: assert property (@(posedge wb_clk_i) disable iff (mod_reset)
        !(wbs_ack_o && wbs_err_o))
        else $error("slave ack and err high together");

    // no new request while the previous one is still running
    a_start_idle: assert property (@(posedge wb_clk_i) disable iff (mod_reset)
        start_o |-> !$past(busy))
        else $error("start issued while busy");

endmodule

//--- rtl/nor_cycle_engine.sv
// master side cycle engine
// issues the table's bus cycles one by one and reports completion

`timescale 1ns/1ps

`include "nor_defs_defs.svh"

module nor_cycle_engine
    import nor_cmd_pkg::*;
    import nor_bus_pkg::*;
(
    input  logic        wb_clk_i,
    // includes mod_reset
    input  logic        abort_i,
    input  logic        start_i,
    input  nor_cmd_e    cmd_i,
    input  nor_addr_t   addr_i,
    input  nor_data_t   data_i,
    input  cycle_idx_t  cycle_cnt_i,
    input  const_addr_t const_addr_i,
    input  nor_data_t   const_data_i,
    input  logic        addr_sel_i,
    input  logic        data_sel_i,
    input  logic        wbm_ack_i,
    input  logic        wbm_stall_i,
    input  nor_data_t   wbm_dat_i,
    output cycle_idx_t  cycle_o,
    output nor_addr_t   wbm_adr_o,
    output nor_data_t   wbm_dat_o,
    output logic        wbm_we_o,
    output logic        wbm_stb_o,
    output logic        wbm_cyc_o,
    output logic        done_o,
    output nor_data_t   rd_data_o
);

    seq_state_e state;
    cycle_idx_t cycle_next;
    logic       last_cycle;
    logic       final_ack;

    assign cycle_next = cycle_o + cycle_idx_t'(1);
    assign last_cycle = (cycle_next == cycle_cnt_i);
    assign final_ack  = (state == SEQ_WAIT) && wbm_ack_i && last_cycle;

    // table word or caller word, table addresses zero extended
    assign wbm_adr_o = addr_sel_i ? addr_i : nor_addr_t'(const_addr_i);
    assign wbm_dat_o = data_sel_i ? data_i : const_data_i;

    always_ff @(posedge wb_clk_i) begin
        if (abort_i) begin
            state     <= SEQ_IDLE;
            cycle_o   <= '0;
            wbm_cyc_o <= 1'b0;
            wbm_stb_o <= 1'b0;
            wbm_we_o  <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (start_i) begin
                        cycle_o <= '0;
                        state   <= SEQ_ISSUE;
                    end
                end

                // wait out stall, then one strobe
                SEQ_ISSUE: begin
                    if (!wbm_stall_i) begin
                        wbm_cyc_o <= 1'b1;
                        wbm_stb_o <= 1'b1;
                        // only plain reads drive we low
                        wbm_we_o  <= (cmd_i != CMD_READ);
                        state     <= SEQ_WAIT;
                    end
                end

                SEQ_WAIT: begin
                    wbm_stb_o <= 1'b0;
                    wbm_we_o  <= 1'b0;
                    if (wbm_ack_i) begin
                        wbm_cyc_o <= 1'b0;
                        if (last_cycle) begin
                            done_o  <= 1'b1;
                            cycle_o <= '0;
                            state   <= SEQ_IDLE;
                        end else begin
                            cycle_o <= cycle_next;
                            state   <= SEQ_ISSUE;
                        end
                    end
                end

                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // read data from the final ack, lands together with done
    always_ff @(posedge wb_clk_i) begin
        if (final_ack && cmd_i == CMD_READ) begin
            rd_data_o <= wbm_dat_i;
        end
    end

    // strobe only inside a bus cycle
    a_stb_in_cyc: assert property (@(posedge wb_clk_i) disable iff (abort_i)
        wbm_stb_o |-> wbm_cyc_o)
        else $error("master stb without cyc");

    // index against the table count for the latched opcode
    a_idx_range: assert property (@(posedge wb_clk_i) disable iff (abort_i)
        (state != SEQ_IDLE) |-> (cycle_o < cycle_cnt_i))
        else $error("cycle index %0d beyond count %0d", cycle_o, cycle_cnt_i);

endmodule

//--- rtl/wb_nor_controller.sv
// wishbone nor flash controller top
// request latch, cycle engine and command table between slave and master ports

`timescale 1ns/1ps

`include "nor_defs_defs.svh"

module wb_nor_controller
    import nor_cmd_pkg::*;
    import nor_bus_pkg::*;
(
    input  logic      wb_clk_i,
    input  logic      mod_reset,

    // slave port, direction comes from the opcode so we is unused
    input  req_addr_t wbs_adr_i,
    input  nor_data_t wbs_dat_i,
    input  logic      wbs_we_i,
    input  logic      wbs_stb_i,
    input  logic      wbs_cyc_i,
    output logic      wbs_ack_o,
    output logic      wbs_err_o,
    output nor_data_t wbs_dat_o,
    output logic      wbs_stall_o,

    // master port toward the flash
    output nor_addr_t wbm_adr_o,
    output nor_data_t wbm_dat_o,
    output logic      wbm_we_o,
    output logic      wbm_stb_o,
    output logic      wbm_cyc_o,
    input  logic      wbm_ack_i,
    input  logic      wbm_err_i,
    input  nor_data_t wbm_dat_i,
    input  logic      wbm_stall_i
);

    // latch to engine
    logic        start;
    logic        abort;
    nor_cmd_e    cmd;
    nor_addr_t   addr;
    nor_data_t   data;

    // engine to latch
    logic        done;
    nor_data_t   rd_data;

    // engine and table
    cycle_idx_t  cycle;
    cycle_idx_t  cycle_cnt;
    const_addr_t const_addr;
    nor_data_t   const_data;
    logic        addr_sel;
    logic        data_sel;

    nor_req_latch u_req_latch (
        .wb_clk_i    (wb_clk_i),
        .mod_reset   (mod_reset),
        .wbs_adr_i   (wbs_adr_i),
        .wbs_dat_i   (wbs_dat_i),
        .wbs_stb_i   (wbs_stb_i),
        .wbs_cyc_i   (wbs_cyc_i),
        .wbm_err_i   (wbm_err_i),
        .done_i      (done),
        .rd_data_i   (rd_data),
        .wbs_ack_o   (wbs_ack_o),
        .wbs_stall_o (wbs_stall_o),
        .wbs_err_o   (wbs_err_o),
        .wbs_dat_o   (wbs_dat_o),
        .start_o     (start),
        .abort_o     (abort),
        .cmd_o       (cmd),
        .addr_o      (addr),
        .data_o      (data)
    );

    nor_cycle_engine u_cycle_engine (
        .wb_clk_i     (wb_clk_i),
        .abort_i      (abort),
        .start_i      (start),
        .cmd_i        (cmd),
        .addr_i       (addr),
        .data_i       (data),
        .cycle_cnt_i  (cycle_cnt),
        .const_addr_i (const_addr),
        .const_data_i (const_data),
        .addr_sel_i   (addr_sel),
        .data_sel_i   (data_sel),
        .wbm_ack_i    (wbm_ack_i),
        .wbm_stall_i  (wbm_stall_i),
        .wbm_dat_i    (wbm_dat_i),
        .cycle_o      (cycle),
        .wbm_adr_o    (wbm_adr_o),
        .wbm_dat_o    (wbm_dat_o),
        .wbm_we_o     (wbm_we_o),
        .wbm_stb_o    (wbm_stb_o),
        .wbm_cyc_o    (wbm_cyc_o),
        .done_o       (done),
        .rd_data_o    (rd_data)
    );

    nor_cmd_table u_cmd_table (
        .cmd_i        (cmd),
        .cycle_i      (cycle),
        .cycle_cnt_o  (cycle_cnt),
        .const_addr_o (const_addr),
        .const_data_o (const_data),
        .addr_sel_o   (addr_sel),
        .data_sel_o   (data_sel)
    );

endmodule

//--- dv/nor_flash_model.sv
// nor flash bus responder for simulation
// random stall, ack 0 to 3 cycles after each strobe, error on request

`timescale 1ns/1ps

module nor_flash_model (
    input  logic        wb_clk_i,
    input  logic        mod_reset,
    input  logic [25:0] adr_i,
    input  logic        stb_i,
    input  logic        cyc_i,
    // raise err instead of ack on the next strobe
    input  logic        err_req_i,
    output logic        ack_o,
    output logic        err_o,
    output logic        stall_o,
    output logic [15:0] dat_o
);

    logic        s_stb;
    logic        s_cyc;
    logic        s_rst;
    logic        s_err;
    logic [25:0] s_adr;
    logic        pending;
    int          delay;
    logic [15:0] rd_word;

    initial begin
        ack_o   = 1'b0;
        err_o   = 1'b0;
        stall_o = 1'b0;
        dat_o   = '0;
        pending = 1'b0;
        delay   = 0;
        rd_word = '0;
        forever begin
            @(posedge wb_clk_i);
            // bus values as seen at the edge
            s_stb = stb_i;
            s_cyc = cyc_i;
            s_rst = mod_reset;
            s_err = err_req_i;
            s_adr = adr_i;
            #0.5;
            ack_o   = 1'b0;
            err_o   = 1'b0;
            stall_o = (($urandom % 4) == 0);
            if (s_rst || !s_cyc) begin
                // bus cycle gone, forget any ack in flight
                pending = 1'b0;
            end else if (s_stb) begin
                if (s_err) begin
                    err_o = 1'b1;
                end else begin
                    pending = 1'b1;
                    delay   = $urandom % 4;
                    rd_word = s_adr[15:0] ^ 16'hA5A5;
                end
            end
            if (pending) begin
                if (delay == 0) begin
                    ack_o   = 1'b1;
                    dat_o   = rd_word;
                    pending = 1'b0;
                end else begin
                    delay = delay - 1;
                end
            end
        end
    end

endmodule

//--- dv/tb_wb_nor_controller.sv
// testbench for the wishbone nor flash controller
// expected bus cycles per request, checked by concurrent assertions

`timescale 1ns/1ps

module tb_wb_nor_controller
    import nor_cmd_pkg::*;
    import nor_bus_pkg::*;
;

    localparam int CYCLE_LIMIT = 6000;
    localparam int WAIT_LIMIT  = 200;

    logic        wb_clk_i = 1'b0;
    logic        mod_reset;
    req_addr_t   wbs_adr_i;
    nor_data_t   wbs_dat_i;
    logic        wbs_we_i;
    logic        wbs_stb_i;
    logic        wbs_cyc_i;
    logic        wbs_ack_o;
    logic        wbs_err_o;
    nor_data_t   wbs_dat_o;
    logic        wbs_stall_o;
    nor_addr_t   wbm_adr_o;
    nor_data_t   wbm_dat_o;
    logic        wbm_we_o;
    logic        wbm_stb_o;
    logic        wbm_cyc_o;
    logic        wbm_ack_i;
    logic        wbm_err_i;
    nor_data_t   wbm_dat_i;
    logic        wbm_stall_i;
    logic        err_req;

    // expected sequence of the current request
    logic [25:0] exp_adr_a [0:7];
    logic [15:0] exp_dat_a [0:7];
    logic        exp_we;
    int          exp_n;
    logic        rd_chk;
    logic [15:0] exp_rd;
    logic        ack_expected;
    logic        in_flight;
    string       test_name;

    // running event counts, per request offsets
    logic [31:0] stb_total = 0;
    logic [31:0] mack_total = 0;
    logic [31:0] sack_total = 0;
    logic [31:0] stb_base;
    logic [31:0] mack_base;
    logic [31:0] sack_base;
    logic [31:0] stb_idx;
    logic [25:0] cur_adr;
    logic [15:0] cur_dat;
    int          err_cnt = 0;
    int          proto_cnt = 0;
    int          cycles = 0;

    assign stb_idx = stb_total - stb_base;
    assign cur_adr = exp_adr_a[stb_idx[2:0]];
    assign cur_dat = exp_dat_a[stb_idx[2:0]];

    always #2 wb_clk_i = ~wb_clk_i;

    wb_nor_controller wb_nor_controller_i (
        .wb_clk_i    (wb_clk_i),
        .mod_reset   (mod_reset),
        .wbs_adr_i   (wbs_adr_i),
        .wbs_dat_i   (wbs_dat_i),
        .wbs_we_i    (wbs_we_i),
        .wbs_stb_i   (wbs_stb_i),
        .wbs_cyc_i   (wbs_cyc_i),
        .wbs_ack_o   (wbs_ack_o),
        .wbs_err_o   (wbs_err_o),
        .wbs_dat_o   (wbs_dat_o),
        .wbs_stall_o (wbs_stall_o),
        .wbm_adr_o   (wbm_adr_o),
        .wbm_dat_o   (wbm_dat_o),
        .wbm_we_o    (wbm_we_o),
        .wbm_stb_o   (wbm_stb_o),
        .wbm_cyc_o   (wbm_cyc_o),
        .wbm_ack_i   (wbm_ack_i),
        .wbm_err_i   (wbm_err_i),
        .wbm_dat_i   (wbm_dat_i),
        .wbm_stall_i (wbm_stall_i)
    );

    nor_flash_model flash (
        .wb_clk_i  (wb_clk_i),
        .mod_reset (mod_reset),
        .adr_i     (wbm_adr_o),
        .stb_i     (wbm_stb_o),
        .cyc_i     (wbm_cyc_o),
        .err_req_i (err_req),
        .ack_o     (wbm_ack_i),
        .err_o     (wbm_err_i),
        .stall_o   (wbm_stall_i),
        .dat_o     (wbm_dat_i)
    );

    always @(posedge wb_clk_i) begin
        if (!mod_reset) begin
            if (wbm_stb_o) stb_total <= stb_total + 1;
            if (wbm_ack_i) mack_total <= mack_total + 1;
            if (wbs_ack_o) sack_total <= sack_total + 1;
        end
    end

    // hard stop for a hung run
    always @(posedge wb_clk_i) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", CYCLE_LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    // each strobe carries the expected word
    a_adr: assert property (@(posedge wb_clk_i) disable iff (mod_reset)
        wbm_stb_o |-> wbm_adr_o == cur_adr)
        else begin
            err_cnt++;
            $display("ERR %s adr exp %h got %h", test_name, cur_adr, wbm_adr_o);
        end
    a_dat: assert property (@(posedge wb_clk_i) disable iff (mod_reset)
        wbm_stb_o |-> wbm_dat_o == cur_dat)
        else begin
            err_cnt++;
            $display("ERR %s dat exp %h got %h", test_name, cur_dat, wbm_dat_o);
        end
    a_we: assert property (@(posedge wb_clk_i) disable iff (mod_reset)
        wbm_stb_o |-> wbm_we_o == exp_we)
        else begin
            err_cnt++;
            $display("ERR %s we exp %b got %b", test_name, exp_we, wbm_we_o);
        end
    a_stb_cnt: assert property (@(posedge wb_clk_i) disable iff (mod_reset)
        wbm_stb_o |-> stb_idx < exp_n)
        else begin
            err_cnt++;
            $display("%s: more master strobes than the command has cycles", test_name);
        end

    // one slave ack, only after the last bus cycle
    a_ack: assert property (@(posedge wb_clk_i) disable iff (mod_reset)
        wbs_ack_o |-> ack_expected && stb_idx == exp_n &&
        (mack_total - mack_base) == exp_n && sack_total == sack_base)
        else begin
            err_cnt++;
            $display("%s: slave ack at the wrong point or repeated", test_name);
        end
    a_rd: assert property (@(posedge wb_clk_i) disable iff (mod_reset)
        wbs_ack_o && rd_chk |-> wbs_dat_o == exp_rd)
        else begin
            err_cnt++;
            $display("ERR %s rd exp %h got %h", test_name, exp_rd, wbs_dat_o);
        end

    // stall behavior on both ports
    a_no_stb_stall: assert property (@(posedge wb_clk_i) disable iff (mod_reset)
        $rose(wbm_stb_o) |-> !$past(wbm_stall_i))
        else begin
            err_cnt++;
            $display("%s: master strobe raised during stall", test_name);
        end
    a_busy: assert property (@(posedge wb_clk_i) disable iff (mod_reset)
        in_flight && !wbs_ack_o |-> wbs_stall_o)
        else begin
            err_cnt++;
            $display("%s: slave stall dropped before ack", test_name);
        end
    a_accept: assert property (@(posedge wb_clk_i) disable iff (mod_reset)
        $rose(wbs_stall_o) |-> !$past(in_flight) || $past(wbs_ack_o))
        else begin
            err_cnt++;
            $display("%s: held request accepted before ack", test_name);
        end

    // aborts
    a_err_pass: assert property (@(posedge wb_clk_i) disable iff (mod_reset)
        wbm_err_i |-> wbs_err_o)
        else begin
            err_cnt++;
            $display("%s: flash error not passed to the slave port", test_name);
        end
    a_err_abort: assert property (@(posedge wb_clk_i) disable iff (mod_reset)
        wbm_err_i |=> !wbm_cyc_o)
        else begin
            err_cnt++;
            $display("%s: master cycle still open after error", test_name);
        end
    a_cyc_abort: assert property (@(posedge wb_clk_i) disable iff (mod_reset)
        !wbs_cyc_i |=> !wbm_cyc_o && !wbs_stall_o)
        else begin
            err_cnt++;
            $display("%s: request not aborted when caller dropped cyc", test_name);
        end
    a_reset: assert property (@(posedge wb_clk_i)
        $fell(mod_reset) |-> !wbs_ack_o && !wbs_stall_o && !wbm_cyc_o &&
        !wbm_stb_o && !wbm_we_o)
        else begin
            err_cnt++;
            $display("%s: outputs not idle after reset", test_name);
        end

    task automatic set_cycle(input int i, input logic [25:0] adr, input logic [15:0] dat);
        exp_adr_a[i] = adr;
        exp_dat_a[i] = dat;
    endtask

    task automatic set_unlock(input int i);
        set_cycle(i, 26'h555, 16'h00AA);
        set_cycle(i + 1, 26'h2AA, 16'h0055);
    endtask

    // expected cycles straight from the command set
    task automatic load_expect(input logic [5:0] op, input logic [25:0] a,
                               input logic [15:0] d);
        exp_n = 1;
        set_cycle(0, 26'h000, 16'h00F0);
        case (op)
            6'd0, 6'd8: set_cycle(0, a, d);
            6'd1: set_cycle(0, 26'h055, 16'h0098);
            6'd2: begin
                set_unlock(0);
                set_cycle(2, 26'h555, 16'h00A0);
                set_cycle(3, a, d);
                exp_n = 4;
            end
            6'd3, 6'd4: begin
                set_unlock(0);
                set_cycle(2, 26'h555, 16'h0080);
                set_unlock(3);
                if (op == 6'd3) set_cycle(5, a, 16'h0030);
                else set_cycle(5, 26'h555, 16'h0010);
                exp_n = 6;
            end
            6'd6: begin
                set_unlock(0);
                set_cycle(2, a, d);
                set_cycle(3, a, d);
                exp_n = 4;
            end
            6'd7: set_cycle(0, a, 16'h0029);
            default: begin
            end
        endcase
        exp_we       = (op != 6'd0);
        rd_chk       = (op == 6'd0);
        exp_rd       = a[15:0] ^ 16'hA5A5;
        ack_expected = 1'b1;
        stb_base     = stb_total;
        mack_base    = mack_total;
        sack_base    = sack_total;
    endtask

    task automatic present(input logic [5:0] op, input logic [25:0] a, input logic [15:0] d);
        wbs_adr_i = {op, a};
        wbs_dat_i = d;
        wbs_we_i  = 1'($urandom % 2);
        wbs_stb_i = 1'b1;
    endtask

    task automatic wait_accept();
        int n;
        n = 0;
        do begin
            @(posedge wb_clk_i);
            n++;
        end while (!(wbs_stb_i && !wbs_stall_o) && n < WAIT_LIMIT);
        if (n >= WAIT_LIMIT) begin
            proto_cnt++;
            $display("%s: request was never accepted", test_name);
        end
        #0.5;
    endtask

    // ends on a slave ack or error
    task automatic wait_finish();
        int n;
        n = 0;
        do begin
            @(posedge wb_clk_i);
            n++;
        end while (!wbs_ack_o && !wbs_err_o && n < WAIT_LIMIT);
        if (n >= WAIT_LIMIT) begin
            proto_cnt++;
            $display("%s: no slave ack or error", test_name);
        end
        #0.5;
    endtask

    task automatic wait_strobes(input int cnt);
        int n;
        n = 0;
        while (stb_idx < cnt && n < WAIT_LIMIT) begin
            @(posedge wb_clk_i);
            #0.5;
            n++;
        end
        if (stb_idx < cnt) begin
            proto_cnt++;
            $display("%s: expected master strobes never came", test_name);
        end
    endtask

    task automatic request(input string name, input logic [5:0] op,
                           input logic [25:0] a, input logic [15:0] d);
        test_name = name;
        load_expect(op, a, d);
        present(op, a, d);
        wait_accept();
        wbs_stb_i = 1'b0;
        in_flight = 1'b1;
        wait_finish();
        in_flight = 1'b0;
    endtask

    task automatic apply_reset();
        mod_reset = 1'b1;
        wbs_stb_i = 1'b0;
        in_flight = 1'b0;
        repeat (4) @(posedge wb_clk_i);
        #0.5;
        mod_reset = 1'b0;
    endtask

    initial begin
        logic [25:0] a;
        logic [15:0] d;
        void'($urandom(53));
        mod_reset    = 1'b1;
        wbs_adr_i    = '0;
        wbs_dat_i    = '0;
        wbs_we_i     = 1'b0;
        wbs_stb_i    = 1'b0;
        wbs_cyc_i    = 1'b1;
        err_req      = 1'b0;
        in_flight    = 1'b0;
        ack_expected = 1'b0;
        rd_chk       = 1'b0;
        exp_n        = 0;
        exp_we       = 1'b0;
        stb_base     = 0;
        mack_base    = 0;
        sack_base    = 0;
        test_name    = "reset";
        #0.5;
        apply_reset();

        // every defined opcode, then a few reads
        for (int op = 0; op < 9; op++) begin
            request($sformatf("cmd_%0d", op), op[5:0], 26'($urandom), 16'($urandom));
        end
        request("read_low", 6'd0, 26'h0000123, 16'h0);
        request("read_high", 6'd0, 26'h3FFFFFF, 16'h0);

        // undefined opcodes fall back to reset
        for (int op = 9; op < 64; op++) begin
            request($sformatf("undef_%0d", op), op[5:0], 26'($urandom), 16'($urandom));
        end

        // second request held on the bus while the first runs
        test_name = "back_to_back";
        load_expect(6'd3, 26'h0ABCDE, 16'h1234);
        present(6'd3, 26'h0ABCDE, 16'h1234);
        wait_accept();
        in_flight = 1'b1;
        present(6'd0, 26'h0004321, 16'h0);
        wait_finish();
        load_expect(6'd0, 26'h0004321, 16'h0);
        wbs_stb_i = 1'b0;
        wait_finish();
        in_flight = 1'b0;

        // flash error in the middle of a chip erase
        test_name = "err_abort";
        load_expect(6'd4, 26'h0, 16'h0);
        present(6'd4, 26'h0, 16'h0);
        wait_accept();
        wbs_stb_i = 1'b0;
        in_flight = 1'b1;
        wait_strobes(2);
        ack_expected = 1'b0;
        err_req      = 1'b1;
        wait_finish();
        err_req   = 1'b0;
        in_flight = 1'b0;
        repeat (3) @(posedge wb_clk_i);
        #0.5;
        request("after_err", 6'd2, 26'($urandom), 16'($urandom));

        // caller gives up during a program
        test_name = "cyc_drop";
        a = 26'($urandom);
        d = 16'($urandom);
        load_expect(6'd2, a, d);
        present(6'd2, a, d);
        wait_accept();
        wbs_stb_i = 1'b0;
        in_flight = 1'b1;
        wait_strobes(1);
        ack_expected = 1'b0;
        in_flight    = 1'b0;
        wbs_cyc_i    = 1'b0;
        @(posedge wb_clk_i);
        #0.5;
        wbs_cyc_i = 1'b1;
        repeat (3) @(posedge wb_clk_i);
        #0.5;
        request("after_drop", 6'd6, 26'($urandom), 16'($urandom));

        // reset lands while a chip erase holds the master cycle open
        test_name = "mid_reset";
        load_expect(6'd4, 26'h0, 16'h0);
        present(6'd4, 26'h0, 16'h0);
        wait_accept();
        wbs_stb_i = 1'b0;
        in_flight = 1'b1;
        wait_strobes(2);
        ack_expected = 1'b0;
        apply_reset();
        for (int i = 0; i < 10; i++) begin
            request($sformatf("rand_%0d", i), 6'($urandom % 64), 26'($urandom),
                    16'($urandom));
        end

        repeat (5) @(posedge wb_clk_i);
        $display("checks done: %0d assertion errors, %0d handshake errors",
                 err_cnt, proto_cnt);
        if (err_cnt == 0 && proto_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+include
rtl/nor_cmd_pkg.sv
rtl/nor_bus_pkg.sv
rtl/nor_cmd_table.sv
rtl/nor_req_latch.sv
rtl/nor_cycle_engine.sv
rtl/wb_nor_controller.sv
dv/nor_flash_model.sv
dv/tb_wb_nor_controller.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only if the pass line is printed
verilator --binary --timing --assert -f project.f \
    --top-module tb_wb_nor_controller -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -qx "all tests passed" \
    || { echo "simulation did not pass"; exit 1; }
